//--- src/histogram_settings.svh
`ifndef HISTOGRAM_SETTINGS_SVH
`define HISTOGRAM_SETTINGS_SVH

// sizing of the histogram engine

// number of pixel lanes
// must stay a power of two so every index is a valid lane
`define NUM_PIXELS 4

// bits needed for a pixel index
`define PIX_BITS ($clog2(`NUM_PIXELS))

// raw timestamp width from the TDC
`define TS_BITS 10

// upper timestamp bits that pick the bin, 64 bins
`define BIN_BITS 6

// one bin count, saturates at all ones
`define COUNT_BITS 8

`endif

//--- src/tdcPkg.sv
`include "histogram_settings.svh"

// word format on the input stream
package tdcPkg;

    // kind bit in front of every payload
    typedef enum logic {
        kindEvent   = 1'b0,
        kindCommand = 1'b1
    } wordKind_t;

    // command opcodes, only frame end is acted on
    typedef enum logic [1:0] {
        opNop      = 2'd0,
        opFrameEnd = 2'd1
    } tdcOpcode_t;

    // spare bits so a command fills the event width
    localparam int cmdPadBits = `PIX_BITS + `TS_BITS - 2 - `COUNT_BITS;

    // hit from one pixel
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`TS_BITS-1:0]  timestamp;
    } tdcEvent_t;

    // acquisition control, threshold travels with frame end
    typedef struct packed {
        tdcOpcode_t             opcode;
        logic [`COUNT_BITS-1:0] threshold;
        logic [cmdPadBits-1:0]  pad;
    } tdcCommand_t;

    // same 12 bits, meaning set by the kind bit
    typedef union packed {
        tdcEvent_t   ev;
        tdcCommand_t cmd;
    } tdcPayload_t;

    typedef struct packed {
        wordKind_t   kind;
        tdcPayload_t payload;
    } tdcWord_t;

endpackage

//--- src/histPkg.sv
`include "histogram_settings.svh"

// types seen on the lane side of the dispatcher
package histPkg;

    // what one lane gets per transfer
    // bin is only meaningful for events
    // threshold only for frame end
    typedef struct packed {
        logic [`BIN_BITS-1:0]   bin;
        logic                   isFrameEnd;
        logic [`COUNT_BITS-1:0] threshold;
    } laneOp_t;

    // per pixel summary posted at frame end
    typedef struct packed {
        logic [`PIX_BITS-1:0]   pixel;
        logic [`BIN_BITS-1:0]   peakBin;
        logic [`COUNT_BITS-1:0] peakCount;
        // peak count reached the frame threshold
        logic                   detected;
    } peakResult_t;

endpackage

//--- src/eventDispatcher.sv
`timescale 1ns/1ns
`include "histogram_settings.svh"

// input stage of the engine
// one word register feeding all lanes
module eventDispatcher import tdcPkg::*, histPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  tdcWord_t               inWord,
    input  logic                   inValid,
    output logic                   inReady,
    output laneOp_t                laneOp,
    output logic [`NUM_PIXELS-1:0] laneValid,
    input  logic [`NUM_PIXELS-1:0] laneReady
);

    // lanes that still owe an accept for the held word
    logic [`NUM_PIXELS-1:0] pendMask;
    logic [`NUM_PIXELS-1:0] remainMask;
    logic [`NUM_PIXELS-1:0] eventMask;
    logic                   isCommand;
    logic                   isFrameEnd;
    logic                   started;
    logic                   accept;
    laneOp_t                nextOp;

    // decode by kind bit
    assign isCommand  = inWord.kind == kindCommand;
    assign isFrameEnd = isCommand && (inWord.payload.cmd.opcode == opFrameEnd);

    // one hot on the target pixel
    assign eventMask = {{(`NUM_PIXELS-1){1'b0}}, 1'b1} << inWord.payload.ev.pixel;

    // lanes not taking the word this cycle
    assign remainMask = pendMask & ~laneReady;

    // free once every lane has taken the held word
    // intake waits one cycle after reset
    assign inReady = started && (remainMask == '0);
    assign accept  = inValid && inReady;

    assign laneValid = pendMask;

    always_comb begin
        // bin from the timestamp msbs
        nextOp.bin        = inWord.payload.ev.timestamp[`TS_BITS-1 -: `BIN_BITS];
        nextOp.isFrameEnd = isFrameEnd;
        nextOp.threshold  = inWord.payload.cmd.threshold;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started  <= 1'b0;
            pendMask <= '0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                if (isFrameEnd) begin
                    // broadcast to every lane
                    pendMask <= '1;
                end else if (isCommand) begin
                    // other opcodes are dropped here
                    pendMask <= '0;
                end else begin
                    pendMask <= eventMask;
                end
            end else begin
                pendMask <= remainMask;
            end
        end
    end

    // word payload
    always_ff @(posedge clk) begin
        if (accept) begin
            laneOp <= nextOp;
        end
    end

    // a word some lane has not yet taken must not move
    assert property (@(posedge clk) disable iff (rst)
        |(laneValid & ~laneReady) |=> $stable(laneOp))
        else $error("laneOp changed while a lane still held it");

endmodule

//--- src/pixelHistogram.sv
`timescale 1ns/1ns
`include "histogram_settings.svh"

// one pixel lane
// bin RAM with read-modify-write, peak tracking and frame end handling
module pixelHistogram import histPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`PIX_BITS-1:0] pixelId,
    input  laneOp_t              laneOp,
    input  logic                 opValid,
    output logic                 opReady,
    output peakResult_t          result,
    output logic                 resultValid,
    input  logic                 resultReady
);

    localparam int numBins = 1 << `BIN_BITS;

    typedef enum logic [2:0] {
        stIdle,
        stDrainA,
        stDrainB,
        stPost,
        stClear
    } laneState_t;

    laneState_t state;

    // bin memory wiped by the clear sequencer
    logic [`COUNT_BITS-1:0] binMem [numBins];

    // stage 1 holds the accepted bin until the RAM read
    logic                   s1Valid;
    logic [`BIN_BITS-1:0]   s1Bin;
    // stage 2 holds the read count until the write
    logic                   s2Valid;
    logic [`BIN_BITS-1:0]   s2Bin;
    logic [`COUNT_BITS-1:0] s2Count;
    logic [`COUNT_BITS-1:0] newCount;
    logic                   fwdHit;

    // running peak of the frame
    logic [`BIN_BITS-1:0]   peakBin;
    logic [`COUNT_BITS-1:0] peakCount;
    logic [`COUNT_BITS-1:0] frameThreshold;

    logic [`BIN_BITS-1:0]   clearAddr;
    logic                   eventAccept;
    logic                   frameAccept;
    logic                   resultFree;
    logic                   postNow;

    assign opReady     = state == stIdle;
    assign eventAccept = opValid && opReady && !laneOp.isFrameEnd;
    assign frameAccept = opValid && opReady && laneOp.isFrameEnd;

    // result slot empty or emptied this cycle
    assign resultFree = !resultValid || resultReady;
    assign postNow    = (state == stPost) && resultFree;

    // saturating increment
    assign newCount = (s2Count == '1) ? s2Count : s2Count + 1'b1;

    // same bin written as it is read takes the count in flight
    assign fwdHit = s2Valid && (s2Bin == s1Bin);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= eventAccept;
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= laneOp.bin;
        s2Bin   <= s1Bin;
        s2Count <= fwdHit ? newCount : binMem[s1Bin];
    end

    // clear owns the single write port while it runs
    always_ff @(posedge clk) begin
        if (state == stClear) begin
            binMem[clearAddr] <= '0;
        end else if (s2Valid) begin
            binMem[s2Bin] <= newCount;
        end
    end

    // strictly greater keeps the first bin to reach the top count
    always_ff @(posedge clk) begin
        if (rst || postNow) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (s2Valid && (newCount > peakCount)) begin
            peakBin   <= s2Bin;
            peakCount <= newCount;
        end
    end

    always_ff @(posedge clk) begin
        if (frameAccept) begin
            frameThreshold <= laneOp.threshold;
        end
    end

    // frame end sequencer
    // reset starts with a clear
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stClear;
            clearAddr   <= '0;
            resultValid <= 1'b0;
        end else begin
            if (resultValid && resultReady) begin
                resultValid <= 1'b0;
            end
            case (state)
                stIdle: begin
                    if (frameAccept) begin
                        state <= stDrainA;
                    end
                end
                // last event still writing
                stDrainA: state <= stDrainB;
                stDrainB: state <= stPost;
                stPost: begin
                    // wait here while the collector is backed up
                    if (resultFree) begin
                        resultValid <= 1'b1;
                        clearAddr   <= '0;
                        state       <= stClear;
                    end
                end
                stClear: begin
                    clearAddr <= clearAddr + 1'b1;
                    if (clearAddr == '1) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (postNow) begin
            result.pixel     <= pixelId;
            result.peakBin   <= peakBin;
            result.peakCount <= peakCount;
            result.detected  <= peakCount >= frameThreshold;
        end
    end

    // pipeline must be empty before the clear takes the write port
    assert property (@(posedge clk) disable iff (rst)
        (state == stClear) |-> !s2Valid)
        else $error("count write during clear");

    // posted result held until the collector takes it
    assert property (@(posedge clk) disable iff (rst)
        resultValid && !resultReady |=> resultValid && $stable(result))
        else $error("lane result changed under back-pressure");

endmodule

//--- src/peakCollector.sv
`timescale 1ns/1ns
`include "histogram_settings.svh"

// merges lane results onto one output
// round robin so no lane starves
module peakCollector import histPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  peakResult_t            laneResult [`NUM_PIXELS],
    input  logic [`NUM_PIXELS-1:0] laneResultValid,
    output logic [`NUM_PIXELS-1:0] laneResultReady,
    output peakResult_t            result,
    output logic                   resultValid,
    input  logic                   resultReady
);

    // first lane to look at next time
    logic [`PIX_BITS-1:0] rrPtr;
    logic [`PIX_BITS-1:0] grantIdx;
    logic                 grantAny;
    logic                 slotFree;

    // output register empty or draining
    assign slotFree = !resultValid || resultReady;

    // search from the pointer, index wraps with its width
    always_comb begin
        logic [`PIX_BITS-1:0] idx;
        grantAny = 1'b0;
        grantIdx = rrPtr;
        for (int i = 0; i < `NUM_PIXELS; i++) begin
            idx = rrPtr + i[`PIX_BITS-1:0];
            if (!grantAny && laneResultValid[idx]) begin
                grantAny = 1'b1;
                grantIdx = idx;
            end
        end
    end

    always_comb begin
        laneResultReady = '0;
        if (slotFree && grantAny) begin
            laneResultReady[grantIdx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            rrPtr       <= '0;
        end else if (slotFree) begin
            resultValid <= grantAny;
            // winner goes to the back
            if (grantAny) begin
                rrPtr <= grantIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slotFree && grantAny) begin
            result <= laneResult[grantIdx];
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(laneResultReady))
        else $error("more than one lane granted");

endmodule

//--- src/sifhTop.sv
`timescale 1ns/1ns
`include "histogram_settings.svh"

// time-of-flight histogram engine
// dispatcher, one lane per pixel, result collector
module sifhTop import tdcPkg::*, histPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  tdcWord_t    inWord,
    input  logic        inValid,
    output logic        inReady,
    output peakResult_t result,
    output logic        resultValid,
    input  logic        resultReady
);

    // dispatcher to lanes
    laneOp_t                laneOp;
    logic [`NUM_PIXELS-1:0] laneValid;
    logic [`NUM_PIXELS-1:0] laneReady;

    // lanes to collector
    peakResult_t            laneResult [`NUM_PIXELS];
    logic [`NUM_PIXELS-1:0] laneResultValid;
    logic [`NUM_PIXELS-1:0] laneResultReady;

    eventDispatcher dispatcher (
        .clk       (clk),
        .rst       (rst),
        .inWord    (inWord),
        .inValid   (inValid),
        .inReady   (inReady),
        .laneOp    (laneOp),
        .laneValid (laneValid),
        .laneReady (laneReady)
    );

    // lane index doubles as the pixel id in results
    for (genvar p = 0; p < `NUM_PIXELS; p++) begin : genLane
        pixelHistogram lane (
            .clk         (clk),
            .rst         (rst),
            .pixelId     (`PIX_BITS'(p)),
            .laneOp      (laneOp),
            .opValid     (laneValid[p]),
            .opReady     (laneReady[p]),
            .result      (laneResult[p]),
            .resultValid (laneResultValid[p]),
            .resultReady (laneResultReady[p])
        );
    end

    peakCollector collector (
        .clk             (clk),
        .rst             (rst),
        .laneResult      (laneResult),
        .laneResultValid (laneResultValid),
        .laneResultReady (laneResultReady),
        .result          (result),
        .resultValid     (resultValid),
        .resultReady     (resultReady)
    );

endmodule

//--- sim/tbSifh.sv
`timescale 1ns/1ns
`include "histogram_settings.svh"

// testbench for the histogram engine
// reference model in the bench and assertions on every result
module tbSifh
    import tdcPkg::*, histPkg::*;
();

    localparam int clkPeriod   = 40;
    localparam int numBins     = 1 << `BIN_BITS;
    localparam int countMax    = (1 << `COUNT_BITS) - 1;
    localparam int maxFrames   = 16;
    localparam int holdCycles  = 300;
    // a clear takes under 70 cycles so a longer stall means back-pressure
    localparam int stallLimit  = 100;
    // events per test in run order
    localparam int totalEvents = 200 + 140 + 560 + 240 + 120 + 248;
    localparam int totalFrames = 10;
    localparam int watchdogCycles = totalEvents * 4 + totalFrames * 200 + holdCycles;

    logic        clk;
    logic        rst;
    tdcWord_t    inWord;
    logic        inValid;
    logic        inReady;
    peakResult_t result;
    logic        resultValid;
    logic        resultReady;

    // model state per pixel
    int          binCount [`NUM_PIXELS][numBins];
    int          peakCntM [`NUM_PIXELS];
    int          peakBinM [`NUM_PIXELS];
    // expected results written at frame end and read in arrival order
    peakResult_t expRes [`NUM_PIXELS][maxFrames];
    int          wrPtr [`NUM_PIXELS];
    int          rdPtr [`NUM_PIXELS];

    logic [31:0] randState;
    logic [31:0] readyState;
    int          readyMode;
    int          stretchLeft;
    logic        stretchLevel;
    int          stallRun;
    logic        stallSeen;
    logic [`BIN_BITS-1:0] t4Bins [30];

    int          mismatchErrors;
    int          extraErrors;
    int          otherErrors;
    int          checks;
    int          testsRun;
    int          errBefore;

    sifhTop u_dut (
        .clk         (clk),
        .rst         (rst),
        .inWord      (inWord),
        .inValid     (inValid),
        .inReady     (inReady),
        .result      (result),
        .resultValid (resultValid),
        .resultReady (resultReady)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] stepLcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int errorTotal();
        return mismatchErrors + extraErrors + otherErrors;
    endfunction

    function automatic logic resultPending(input logic [`PIX_BITS-1:0] pix);
        return rdPtr[pix] < wrPtr[pix];
    endfunction

    function automatic peakResult_t expectedFor(input logic [`PIX_BITS-1:0] pix);
        int slot;
        slot = (rdPtr[pix] < maxFrames) ? rdPtr[pix] : maxFrames - 1;
        return expRes[pix][slot];
    endfunction

    function automatic string resultText(input peakResult_t r);
        return $sformatf("bin %0d count %0d detected %0b", r.peakBin, r.peakCount, r.detected);
    endfunction

    // bin in the upper bits and fine time below
    function automatic logic [`TS_BITS-1:0] tsForBin(input logic [`BIN_BITS-1:0] bin,
                                                     input int fine);
        return {bin, (`TS_BITS-`BIN_BITS)'(fine)};
    endfunction

    // each transfer is checked against the head of that pixel's list
    assert property (@(posedge clk) disable iff (rst)
        resultValid && resultReady && resultPending(result.pixel)
        |-> result == expectedFor(result.pixel))
        else begin
            mismatchErrors = mismatchErrors + 1;
            $display("Mismatch at %0t: pixel %0d got %s, expected %s", $time, result.pixel,
                resultText(result), resultText(expectedFor(result.pixel)));
        end

    // a result nobody asked for is a duplicate
    assert property (@(posedge clk) disable iff (rst)
        resultValid && resultReady |-> resultPending(result.pixel))
        else begin
            extraErrors = extraErrors + 1;
            $display("pixel %0d delivered a result with no frame end pending at %0t",
                result.pixel, $time);
        end

    // advance the read side and watch for long input stalls
    always @(posedge clk) begin
        if (!rst && resultValid && resultReady) begin
            checks <= checks + 1;
            if (resultPending(result.pixel)) begin
                rdPtr[result.pixel] <= rdPtr[result.pixel] + 1;
            end
        end
        if (!rst && inValid && !inReady) begin
            stallRun <= stallRun + 1;
            if (stallRun > stallLimit) begin
                stallSeen <= 1'b1;
            end
        end else begin
            stallRun <= 0;
        end
    end

    // resultReady pattern by mode
    // mode 0 always high, mode 1 random stretches, mode 2 held low
    always @(posedge clk) begin
        #2;
        if (readyMode == 0) begin
            resultReady = 1'b1;
        end else if (readyMode == 2) begin
            resultReady = 1'b0;
        end else begin
            if (stretchLeft == 0) begin
                readyState   = stepLcg(readyState);
                stretchLevel = readyState[20];
                stretchLeft  = 1 + int'(readyState[27:22]);
            end
            stretchLeft  = stretchLeft - 1;
            resultReady  = stretchLevel;
        end
    end

    task automatic nextRand(output logic [31:0] r);
        randState = stepLcg(randState);
        r = randState;
    endtask

    // called 2 ns after an edge and returns 2 ns after the transfer edge
    task automatic sendWord(input tdcWord_t w);
        inWord  = w;
        inValid = 1'b1;
        while (!inReady) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        inValid = 1'b0;
    endtask

    // saturating count where only strictly greater moves the peak
    task automatic countEvent(input logic [`PIX_BITS-1:0] pix, input logic [`BIN_BITS-1:0] bin);
        int c;
        c = binCount[pix][bin];
        if (c < countMax) begin
            c = c + 1;
        end
        binCount[pix][bin] = c;
        if (c > peakCntM[pix]) begin
            peakCntM[pix] = c;
            peakBinM[pix] = int'(bin);
        end
    endtask

    task automatic sendEvent(input logic [`PIX_BITS-1:0] pix, input logic [`TS_BITS-1:0] ts);
        tdcWord_t w;
        w.kind                 = kindEvent;
        w.payload.ev.pixel     = pix;
        w.payload.ev.timestamp = ts;
        sendWord(w);
        countEvent(pix, ts[`TS_BITS-1 -: `BIN_BITS]);
    endtask

    // expected result per pixel and then a fresh model histogram
    task automatic sendFrameEnd(input logic [`COUNT_BITS-1:0] thr);
        tdcWord_t    w;
        peakResult_t e;
        w.kind                  = kindCommand;
        w.payload.cmd.opcode    = opFrameEnd;
        w.payload.cmd.threshold = thr;
        w.payload.cmd.pad       = '0;
        sendWord(w);
        for (int p = 0; p < `NUM_PIXELS; p++) begin
            e.pixel     = `PIX_BITS'(p);
            e.peakBin   = `BIN_BITS'(peakBinM[p]);
            e.peakCount = `COUNT_BITS'(peakCntM[p]);
            e.detected  = peakCntM[p] >= int'(thr);
            expRes[p][wrPtr[p]] = e;
            wrPtr[p] = wrPtr[p] + 1;
            peakCntM[p] = 0;
            peakBinM[p] = 0;
            for (int b = 0; b < numBins; b++) begin
                binCount[p][b] = 0;
            end
        end
    endtask

    task automatic sendRandomEvents(input int n, input logic [`TS_BITS-1:0] tsMask);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            nextRand(r);
            sendEvent(r[31 -: `PIX_BITS], r[`TS_BITS+15:16] & tsMask);
        end
    endtask

    task automatic waitResults(input int limit);
        int   n;
        logic pending;
        n = 0;
        pending = 1'b1;
        while (pending && n < limit) begin
            pending = 1'b0;
            for (int p = 0; p < `NUM_PIXELS; p++) begin
                if (rdPtr[p] < wrPtr[p]) begin
                    pending = 1'b1;
                end
            end
            if (pending) begin
                @(posedge clk);
                #2;
                n = n + 1;
            end
        end
        for (int p = 0; p < `NUM_PIXELS; p++) begin
            if (rdPtr[p] < wrPtr[p]) begin
                otherErrors = otherErrors + 1;
                $display("pixel %0d: %0d result(s) never arrived", p, wrPtr[p] - rdPtr[p]);
            end
        end
    endtask

    task automatic endTest(input string name);
        testsRun = testsRun + 1;
        $display("test %0d %s finished with %0d error(s)", testsRun, name,
            errorTotal() - errBefore);
        errBefore = errorTotal();
    endtask

    // watchdog sized from the test lengths
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, run did not complete", watchdogCycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          len;
        logic [`BIN_BITS-1:0] bin;
        clk = 1'b0;
        rst = 1'b1;
        inWord = '0;
        inValid = 1'b0;
        resultReady = 1'b0;
        randState = 32'h631d;
        readyState = ~32'h631d;
        readyMode = 0;
        stretchLeft = 0;
        stretchLevel = 1'b0;
        stallRun = 0;
        stallSeen = 1'b0;
        mismatchErrors = 0;
        extraErrors = 0;
        otherErrors = 0;
        checks = 0;
        testsRun = 0;
        errBefore = 0;
        for (int p = 0; p < `NUM_PIXELS; p++) begin
            wrPtr[p] = 0;
            rdPtr[p] = 0;
            peakCntM[p] = 0;
            peakBinM[p] = 0;
            for (int b = 0; b < numBins; b++) begin
                binCount[p][b] = 0;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        sendRandomEvents(200, '1);
        sendFrameEnd(8'd3);
        waitResults(400);
        endTest("random events");

        // one back-to-back burst per pixel into one bin
        for (int p = 0; p < `NUM_PIXELS; p++) begin
            nextRand(r);
            len = 4 + int'(r[20:16]);
            bin = r[29:24];
            for (int i = 0; i < len; i++) begin
                sendEvent(`PIX_BITS'(p), tsForBin(bin, i));
            end
        end
        sendFrameEnd(8'd0);
        waitResults(400);
        endTest("same-bin bursts");

        // bin 20 saturates first and bin 7 ties later
        for (int i = 0; i < 280; i++) begin
            sendEvent(`PIX_BITS'(2), tsForBin(6'd20, i));
        end
        for (int i = 0; i < 280; i++) begin
            sendEvent(`PIX_BITS'(2), tsForBin(6'd7, i));
        end
        sendFrameEnd(8'd200);
        waitResults(400);
        endTest("saturation");

        // identical histogram on every pixel with threshold above and then at the peak
        for (int i = 0; i < 30; i++) begin
            nextRand(r);
            t4Bins[i] = `BIN_BITS'(r[18:16]);
        end
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < 30; i++) begin
                for (int p = 0; p < `NUM_PIXELS; p++) begin
                    sendEvent(`PIX_BITS'(p), tsForBin(t4Bins[i], i));
                end
            end
            sendFrameEnd(`COUNT_BITS'(peakCntM[0] + 1 - f));
            waitResults(400);
        end
        endTest("threshold");

        // results held back until lanes and dispatcher stall
        readyMode = 2;
        stallSeen = 1'b0;
        sendRandomEvents(40, '1);
        sendFrameEnd(8'd2);
        sendRandomEvents(40, '1);
        sendFrameEnd(8'd2);
        fork
            begin
                sendRandomEvents(40, '1);
                sendFrameEnd(8'd2);
            end
            begin
                repeat (holdCycles) @(posedge clk);
                readyMode = 1;
            end
        join
        waitResults(2000);
        assert (stallSeen)
            else begin
                otherErrors = otherErrors + 1;
                $display("inReady never dropped while results were held back");
            end
        readyMode = 0;
        endTest("back-pressure");

        // first frame piles into bin 40 and the second frame hits it twice per pixel
        for (int i = 0; i < 50; i++) begin
            for (int p = 0; p < `NUM_PIXELS; p++) begin
                sendEvent(`PIX_BITS'(p), tsForBin(6'd40, i));
            end
        end
        sendFrameEnd(8'd10);
        waitResults(400);
        for (int p = 0; p < `NUM_PIXELS; p++) begin
            for (int i = 0; i < 2; i++) begin
                sendEvent(`PIX_BITS'(p), tsForBin(6'd40, i));
            end
        end
        sendRandomEvents(40, 10'h1ff);
        sendFrameEnd(8'd1);
        waitResults(400);
        endTest("second frame");

        // late duplicates still show up here
        repeat (100) @(posedge clk);
        $display("%0d tests run, %0d results checked, %0d errors", testsRun, checks,
            errorTotal());
        if (errorTotal() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
src/tdcPkg.sv
src/histPkg.sv
src/eventDispatcher.sv
src/pixelHistogram.sv
src/peakCollector.sv
src/sifhTop.sv
sim/tbSifh.sv

//--- Makefile
# Verilator build for the histogram engine testbench

VERILATOR ?= verilator
TOP       ?= tbSifh
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := src/histogram_settings.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
